//--- verilog/av_config_pkg.sv
// AV config shared definitions
`default_nettype none

package av_config_pkg;

	// Bus register offsets
	typedef enum logic [1:0] {
		reg_control = 2'd0,
		reg_status  = 2'd1,
		reg_address = 2'd2,
		reg_data    = 2'd3
	} reg_addr_e;

	// On-board targets, code 3 lands on the second video address
	typedef enum logic [1:0] {
		dev_audio   = 2'd0,
		dev_video_a = 2'd1,
		dev_video_b = 2'd2
	} device_sel_e;

	// Transfer sequencer states
	typedef enum logic [2:0] {
		st_idle       = 3'd0,
		st_pre_write  = 3'd1,
		st_write_xfer = 3'd2,
		st_post_write = 3'd3,
		st_pre_read   = 3'd4,
		st_read_xfer  = 3'd5,
		st_post_read  = 3'd6
	} xfer_state_e;

	// Three bytes, each with an ack slot after it
	localparam int frame_width = 27;
	typedef logic [frame_width-1:0] frame_t;

	// Write addresses, bit 0 set gives the read address
	localparam logic [7:0] audio_dev_addr   = 8'h34;
	localparam logic [7:0] video_a_dev_addr = 8'h40;
	localparam logic [7:0] video_b_dev_addr = 8'h42;

	// Address byte, ack, register byte, ack
	localparam int restart_bit_count = 18;

	// Short serial clock for simulation
	localparam int scl_half_period = 8;
	localparam int div_count_width = $clog2(scl_half_period + 1);
	localparam int bit_count_width = $clog2(frame_width + 1);

	typedef struct packed {
		logic        start;
		logic        is_read;
		device_sel_e device;
		logic [7:0]  reg_index;
		logic [8:0]  wdata;
	} xfer_req_t;

	typedef struct packed {
		logic   start;
		logic   with_restart;
		frame_t frame;
		frame_t restart_frame;
	} serial_cmd_t;

	typedef struct packed {
		logic   done;
		logic   busy;
		frame_t rx_frame;
	} serial_rsp_t;

	typedef struct packed {
		logic       ack_error;
		logic [8:0] rdata;
	} status_t;

endpackage

`default_nettype wire

//--- verilog/av_config_regs.sv
// AV config bus registers
`timescale 1ns/1ps
`default_nettype none

module av_config_regs import av_config_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  reg_addr_e   address,
	input  logic [3:0]  byteenable,
	input  logic        read,
	input  logic        write,
	input  logic [31:0] writedata,
	input  xfer_state_e state,
	input  status_t     status,
	input  logic        busy,
	output logic        internal_reset,
	output logic [31:0] readdata,
	output logic        waitrequest,
	output logic        irq,
	output device_sel_e device,
	output logic [7:0]  reg_index,
	output logic [8:0]  wdata,
	output logic        irq_enable
);
	// Control bits 2:1, the low one enables the interrupt
	logic [1:0] ctrl_low;
	logic       ready;

	// Soft reset takes effect in the cycle of the control write
	assign internal_reset = reset |
		((address == reg_control) & write & byteenable[0] & writedata[0]);

	assign irq_enable = ctrl_low[0];
	// Ready once the sequencer and the serial bus are both idle
	assign ready = (state == st_idle) & ~busy;
	assign irq = irq_enable & ready;

	// Data accesses stall until the sequencer reaches its accept state
	assign waitrequest = (address == reg_data) &
		((write & (state != st_pre_write)) | (read & (state != st_post_read)));

	always_ff @(posedge clk)
	begin
		if (internal_reset)
		begin
			ctrl_low  <= 2'b00;
			device    <= dev_audio;
			reg_index <= 8'h00;
			wdata     <= 9'h000;
		end
		else if (write)
		begin
			if ((address == reg_control) && byteenable[0])
				ctrl_low <= writedata[2:1];
			if ((address == reg_control) && byteenable[2])
				device <= device_sel_e'(writedata[17:16]);
			if ((address == reg_address) && byteenable[0])
				reg_index <= writedata[7:0];
			// Follows the stalled bus, the sequencer copies it in pre_write
			if ((address == reg_data) && byteenable[0])
				wdata[7:0] <= writedata[7:0];
			if ((address == reg_data) && byteenable[1])
				wdata[8] <= writedata[8];
		end
	end

	// Read mux, one cycle of latency
	always_ff @(posedge clk)
	begin
		if (internal_reset)
			readdata <= 32'h0000_0000;
		else if (read)
		begin
			case (address)
				reg_control:
					readdata <= {14'h0000, device, 13'h0000, ctrl_low, 1'b0};
				// Init-done in bit 8 is fixed high
				reg_status:
					readdata <= {23'h000000, 1'b1, 6'h00, ready, status.ack_error};
				reg_address:
					readdata <= {24'h000000, reg_index};
				default:
					readdata <= {23'h000000, status.rdata};
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/av_config_transfer_fsm.sv
// AV config transfer sequencer
`timescale 1ns/1ps
`default_nettype none

module av_config_transfer_fsm import av_config_pkg::*; (
	input  logic        clk,
	input  logic        internal_reset,
	input  reg_addr_e   address,
	input  logic        read,
	input  logic        write,
	input  device_sel_e device,
	input  logic [7:0]  reg_index,
	input  logic [8:0]  wdata,
	input  logic        done,
	input  logic        busy,
	output xfer_state_e state,
	output xfer_req_t   req
);
	xfer_state_e next_state;
	logic        data_write;
	logic        data_read;

	assign data_write = write & (address == reg_data);
	assign data_read  = read & (address == reg_data);

	always_ff @(posedge clk)
	begin
		if (internal_reset)
			state <= st_idle;
		else
			state <= next_state;
	end

	always_comb
	begin
		next_state = st_idle;
		case (state)
			st_idle:
			begin
				// Held off while the serial bus is still running
				if (busy)
					next_state = st_idle;
				else if (data_write)
					next_state = st_pre_write;
				// Codec has no bus read, return the last capture at once
				else if (data_read)
					next_state = (device == dev_audio) ? st_post_read : st_pre_read;
			end
			st_pre_write:
				next_state = st_write_xfer;
			st_write_xfer:
				next_state = done ? st_post_write : st_write_xfer;
			st_pre_read:
				next_state = st_read_xfer;
			st_read_xfer:
				next_state = done ? st_post_read : st_read_xfer;
			default:
				next_state = st_idle;
		endcase
	end

	// Request snapshot, start holds until done
	always_ff @(posedge clk)
	begin
		if (internal_reset)
			req <= '0;
		else if (done)
			req.start <= 1'b0;
		else if ((state == st_pre_write) || (state == st_pre_read))
		begin
			req.start     <= 1'b1;
			req.is_read   <= (state == st_pre_read);
			req.device    <= device;
			req.reg_index <= reg_index;
			req.wdata     <= wdata;
		end
	end

endmodule

`default_nettype wire

//--- verilog/av_config_frame.sv
// AV config I2C frame builder
`timescale 1ns/1ps
`default_nettype none

module av_config_frame import av_config_pkg::*; (
	input  logic        clk,
	input  logic        internal_reset,
	input  xfer_req_t   req,
	input  serial_rsp_t rsp,
	output serial_cmd_t cmd,
	output status_t     status,
	output logic        done,
	output logic        busy
);
	logic [7:0] dev_addr;

	always_comb
	begin
		case (req.device)
			dev_audio:   dev_addr = audio_dev_addr;
			dev_video_a: dev_addr = video_a_dev_addr;
			default:     dev_addr = video_b_dev_addr;
		endcase
	end

	// Ack slots carry 1 so the line is released there
	always_comb
	begin
		cmd.start        = req.start;
		cmd.with_restart = req.is_read;
		// Codec packs data bit 8 under the 7-bit register index
		if (req.device == dev_audio)
			cmd.frame = {dev_addr, 1'b1, req.reg_index[6:0], req.wdata[8], 1'b1,
				req.wdata[7:0], 1'b1};
		else
			cmd.frame = {dev_addr, 1'b1, req.reg_index, 1'b1, req.wdata[7:0], 1'b1};
		// Read address, released data byte, master NACK, unsent tail
		cmd.restart_frame = {dev_addr | 8'h01, 1'b1, 8'hFF, 1'b1, 9'h1FF};
	end

	assign done = rsp.done;
	assign busy = rsp.busy;

	// Ack slots at 18, 9 and 0; on a read bit 0 is our own NACK
	always_ff @(posedge clk)
	begin
		if (internal_reset)
			status <= '0;
		else if (rsp.done)
		begin
			status.ack_error <= rsp.rx_frame[18] | rsp.rx_frame[9] |
				(rsp.rx_frame[0] & ~req.is_read);
			status.rdata <= (req.device == dev_audio) ?
				{rsp.rx_frame[10], rsp.rx_frame[8:1]} : {1'b0, rsp.rx_frame[8:1]};
		end
	end

endmodule

`default_nettype wire

//--- verilog/i2c_serial_engine.sv
// I2C bit-level master
`timescale 1ns/1ps
`default_nettype none

module i2c_serial_engine import av_config_pkg::*; (
	input  logic        clk,
	input  logic        internal_reset,
	input  serial_cmd_t cmd,
	input  logic        sdat_in,
	output serial_rsp_t rsp,
	output logic        sclk,
	output logic        scen,
	output logic        sdat_oe
);
	// Every state lasts one half period of the serial clock
	typedef enum logic [3:0] {
		e_idle,
		e_start,
		e_bit_low,
		e_bit_high,
		e_rs_low,
		e_rs_high,
		e_rs_start,
		e_stop_low,
		e_stop_high
	} engine_state_e;

	engine_state_e              state;
	logic [div_count_width-1:0] div_cnt;
	logic [bit_count_width-1:0] bit_cnt;
	frame_t                     tx_shift;
	frame_t                     rx_frame;
	logic                       restarted;
	logic                       tick;
	logic                       ack_slot;
	logic                       restart_now;
	logic                       last_bit;
	logic                       pull_low;

	assign tick = (div_cnt == div_count_width'(scl_half_period - 1));

	// Ninth bit of each byte, also the master NACK after a read
	assign ack_slot = (bit_cnt == bit_count_width'(8)) |
		(bit_cnt == bit_count_width'(17)) | (bit_cnt == bit_count_width'(26));

	assign restart_now = cmd.with_restart & ~restarted &
		(bit_cnt == bit_count_width'(restart_bit_count - 1));
	assign last_bit = restarted ?
		(bit_cnt == bit_count_width'(restart_bit_count - 1)) :
		(bit_cnt == bit_count_width'(frame_width - 1));

	// Half-period divider, parked in idle
	always_ff @(posedge clk)
	begin
		if (internal_reset || (state == e_idle) || tick)
			div_cnt <= '0;
		else
			div_cnt <= div_cnt + 1'b1;
	end

	always_ff @(posedge clk)
	begin
		if (internal_reset)
		begin
			state     <= e_idle;
			bit_cnt   <= '0;
			restarted <= 1'b0;
		end
		else if (state == e_idle)
		begin
			bit_cnt   <= '0;
			restarted <= 1'b0;
			if (cmd.start)
				state <= e_start;
		end
		else if (tick)
		begin
			case (state)
				e_start:
					state <= e_bit_low;
				e_bit_low:
					state <= e_bit_high;
				e_bit_high:
				begin
					bit_cnt <= bit_cnt + 1'b1;
					if (restart_now)
					begin
						state     <= e_rs_low;
						bit_cnt   <= '0;
						restarted <= 1'b1;
					end
					else if (last_bit)
						state <= e_stop_low;
					else
						state <= e_bit_low;
				end
				e_rs_low:
					state <= e_rs_high;
				e_rs_high:
					state <= e_rs_start;
				e_rs_start:
					state <= e_bit_low;
				e_stop_low:
					state <= e_stop_high;
				default:
					state <= e_idle;
			endcase
		end
	end

	// MSB first, sample at the end of the high phase
	always_ff @(posedge clk)
	begin
		if (state == e_idle)
			tx_shift <= cmd.frame;
		else if ((state == e_bit_high) && tick)
		begin
			rx_frame <= {rx_frame[frame_width-2:0], sdat_in};
			if (restart_now)
				tx_shift <= cmd.restart_frame;
			else
				tx_shift <= {tx_shift[frame_width-2:0], 1'b1};
		end
	end

	always_comb
	begin
		case (state)
			e_start, e_rs_start, e_stop_low, e_stop_high:
				pull_low = 1'b1;
			e_bit_low, e_bit_high:
				pull_low = ~tx_shift[frame_width-1] & ~ack_slot;
			default:
				pull_low = 1'b0;
		endcase
	end

	// Data lags the clock edge by one cycle
	always_ff @(posedge clk)
	begin
		if (internal_reset)
			sdat_oe <= 1'b0;
		else
			sdat_oe <= pull_low;
	end

	assign sclk = ~((state == e_bit_low) | (state == e_rs_low) | (state == e_stop_low));
	assign scen = (state == e_idle);

	assign rsp.done     = (state == e_stop_high) & tick;
	assign rsp.busy     = (state != e_idle);
	assign rsp.rx_frame = rx_frame;

endmodule

`default_nettype wire

//--- verilog/av_config.sv
// AV config port top level
`timescale 1ns/1ps
`default_nettype none

module av_config import av_config_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [1:0]  address,
	input  logic [3:0]  byteenable,
	input  logic        read,
	input  logic        write,
	input  logic [31:0] writedata,
	output logic [31:0] readdata,
	output logic        waitrequest,
	output logic        irq,
	output logic        i2c_sclk,
	output logic        i2c_scen,
	output logic        i2c_sdat_oe,
	input  logic        i2c_sdat_in
);
	logic        internal_reset;
	device_sel_e device;
	logic [7:0]  reg_index;
	logic [8:0]  wdata;
	xfer_state_e state;
	xfer_req_t   req;
	serial_cmd_t cmd;
	serial_rsp_t rsp;
	status_t     status;
	logic        done;
	logic        busy;

	av_config_regs u_regs (
		.clk            (clk),
		.reset          (reset),
		.address        (reg_addr_e'(address)),
		.byteenable     (byteenable),
		.read           (read),
		.write          (write),
		.writedata      (writedata),
		.state          (state),
		.status         (status),
		.busy           (busy),
		.internal_reset (internal_reset),
		.readdata       (readdata),
		.waitrequest    (waitrequest),
		.irq            (irq),
		.device         (device),
		.reg_index      (reg_index),
		.wdata          (wdata),
		.irq_enable     ()
	);

	av_config_transfer_fsm u_fsm (
		.clk            (clk),
		.internal_reset (internal_reset),
		.address        (reg_addr_e'(address)),
		.read           (read),
		.write          (write),
		.device         (device),
		.reg_index      (reg_index),
		.wdata          (wdata),
		.done           (done),
		.busy           (busy),
		.state          (state),
		.req            (req)
	);

	av_config_frame u_frame (
		.clk            (clk),
		.internal_reset (internal_reset),
		.req            (req),
		.rsp            (rsp),
		.cmd            (cmd),
		.status         (status),
		.done           (done),
		.busy           (busy)
	);

	// Pad join of the data pin lives in the board wrapper
	i2c_serial_engine u_engine (
		.clk            (clk),
		.internal_reset (internal_reset),
		.cmd            (cmd),
		.sdat_in        (i2c_sdat_in),
		.rsp            (rsp),
		.sclk           (i2c_sclk),
		.scen           (i2c_scen),
		.sdat_oe        (i2c_sdat_oe)
	);

endmodule

`default_nettype wire

//--- tests/i2c_device_model.sv
// I2C target model
`timescale 1ns/1ps
`default_nettype none

module i2c_device_model (
	input  logic        scl,
	input  logic        sda,
	input  logic        nack_en,
	output logic        pull_low,
	output logic [23:0] rec_bytes
);
	// Two video targets share one memory, upper half for 8'h42
	logic [7:0] mem [0:511];
	logic       last_scl;
	logic       last_sda;
	logic       active;
	logic       addressed;
	logic       rw;
	logic       dev_b;
	logic       codec;
	logic [3:0] bit_cnt;
	logic [2:0] byte_idx;
	logic [7:0] shift;
	logic [7:0] ptr;
	logic [7:0] tx;
	int         i;

	initial
	begin
		pull_low  = 1'b0;
		rec_bytes = 24'h0;
		last_scl  = 1'b1;
		last_sda  = 1'b1;
		active    = 1'b0;
		addressed = 1'b0;
		rw        = 1'b0;
		dev_b     = 1'b0;
		codec     = 1'b0;
		bit_cnt   = 4'd0;
		byte_idx  = 3'd0;
		shift     = 8'h00;
		ptr       = 8'h00;
		tx        = 8'h00;
		// Fill pattern mixes in the device bit too
		for (i = 0; i < 512; i++)
			mem[i] = 8'((i * 29) ^ (i >> 3) ^ 8'h5a);
	end

	// Byte complete, decode address or store
	task automatic take_byte;
		begin
			if (byte_idx == 3'd0)
			begin
				addressed = (shift[7:1] == 7'h1a) || (shift[7:1] == 7'h20) ||
					(shift[7:1] == 7'h21);
				rw    = shift[0];
				dev_b = (shift[7:1] == 7'h21);
				codec = (shift[7:1] == 7'h1a);
				if (rw)
					tx = mem[{dev_b, ptr}];
			end
			else if (byte_idx == 3'd1)
				ptr = shift;
			else if ((byte_idx == 3'd2) && !codec && addressed && !nack_en)
				mem[{dev_b, ptr}] = shift;
			// Bytes of the last write frame
			if (!rw && (byte_idx < 3'd3))
				rec_bytes[23 - 8 * byte_idx -: 8] = shift;
		end
	endtask

	always @(scl or sda)
	begin
		if ((scl === 1'b1) && (last_scl === 1'b1) && (sda !== last_sda))
		begin
			// Data edge under a high clock, start or stop
			if (sda === 1'b0)
			begin
				active    = 1'b1;
				bit_cnt   = 4'd0;
				byte_idx  = 3'd0;
				addressed = 1'b0;
				rw        = 1'b0;
			end
			else if (sda === 1'b1)
				active = 1'b0;
			pull_low = 1'b0;
		end
		else if ((scl === 1'b1) && (last_scl === 1'b0) && active)
		begin
			if ((bit_cnt < 4'd8) && !(rw && (byte_idx != 3'd0)))
				shift = {shift[6:0], sda};
			bit_cnt = bit_cnt + 4'd1;
		end
		else if ((scl === 1'b0) && (last_scl === 1'b1) && active)
		begin
			if (bit_cnt == 4'd8)
			begin
				// Master acks its own read byte
				if (rw && (byte_idx != 3'd0))
					pull_low = 1'b0;
				else
				begin
					take_byte();
					pull_low = addressed && !nack_en;
				end
			end
			else if (bit_cnt == 4'd9)
			begin
				bit_cnt  = 4'd0;
				byte_idx = byte_idx + 3'd1;
				pull_low = rw && addressed && (byte_idx == 3'd1) && !tx[7];
			end
			else if (rw && addressed && (byte_idx == 3'd1))
				pull_low = !tx[4'd7 - bit_cnt];
		end
		last_scl = scl;
		last_sda = sda;
	end

endmodule

`default_nettype wire

//--- tests/av_config_asserts.sv
// AV config protocol assertions
`timescale 1ns/1ps
`default_nettype none

module av_config_asserts (
	input logic       clk,
	input logic       reset,
	input logic [1:0] address,
	input logic       read,
	input logic       write,
	input logic       waitrequest,
	input logic       irq,
	input logic       scen,
	input logic       sclk,
	input logic       done,
	input logic       start
);
	int fail_count = 0;

	// Only the data register may stall
	a_no_stall: assert property (@(posedge clk) disable iff (reset)
		((read || write) && (address != 2'd3)) |-> !waitrequest)
		else begin $error("waitrequest high for a non-data register"); fail_count++; end

	// Interrupt only while the serial bus is idle
	a_irq_idle: assert property (@(posedge clk) disable iff (reset)
		irq |-> scen)
		else begin $error("irq high during a serial transaction"); fail_count++; end

	a_sclk_quiet: assert property (@(posedge clk) disable iff (reset)
		(scen && $past(scen)) |-> $stable(sclk))
		else begin $error("serial clock moved while idle"); fail_count++; end

	a_done_start: assert property (@(posedge clk) disable iff (reset)
		done |-> start)
		else begin $error("done without a pending start"); fail_count++; end

endmodule

bind av_config av_config_asserts u_asserts (
	.clk         (clk),
	.reset       (internal_reset),
	.address     (address),
	.read        (read),
	.write       (write),
	.waitrequest (waitrequest),
	.irq         (irq),
	.scen        (i2c_scen),
	.sclk        (i2c_sclk),
	.done        (done),
	.start       (cmd.start)
);

`default_nettype wire

//--- tests/av_config_tb.sv
// AV config testbench
`timescale 1ns/1ps
`default_nettype none

module av_config_tb import av_config_pkg::*; ();
	// Room for 20 transactions of about 40 serial bit periods
	localparam int watchdog_ns = 20 * 40 * 2 * scl_half_period * 10;

	logic        clk;
	logic        reset;
	logic [1:0]  address;
	logic [3:0]  byteenable;
	logic        read;
	logic        write;
	logic [31:0] writedata;
	logic [31:0] readdata;
	logic        waitrequest;
	logic        irq;
	logic        i2c_sclk;
	logic        i2c_scen;
	logic        i2c_sdat_oe;
	logic        sda;
	logic        model_pull;
	logic        nack_en;
	logic [23:0] rec_bytes;
	logic [31:0] rd;
	logic [31:0] exp_rd;
	logic [7:0]  idx;
	logic [8:0]  d;
	int          errors = 0;
	int          checks = 0;

	// Wired-AND data line
	assign sda = ~(i2c_sdat_oe | model_pull);

	av_config UUT (
		.clk(clk), .reset(reset), .address(address), .byteenable(byteenable),
		.read(read), .write(write), .writedata(writedata), .readdata(readdata),
		.waitrequest(waitrequest), .irq(irq), .i2c_sclk(i2c_sclk), .i2c_scen(i2c_scen),
		.i2c_sdat_oe(i2c_sdat_oe), .i2c_sdat_in(sda)
	);

	i2c_device_model u_model (
		.scl(i2c_sclk), .sda(sda), .nack_en(nack_en),
		.pull_low(model_pull), .rec_bytes(rec_bytes)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		begin
			checks++;
			if (got !== exp)
			begin
				errors++;
				$display("error %0t: %s read %h, expected %h", $time, what, got, exp);
			end
		end
	endtask

	// Hold the access until a cycle without waitrequest
	task automatic bus_access(input logic [1:0] addr, input logic rnw, input logic [31:0] data);
		logic stalled;
		begin
			@(negedge clk);
			address    = addr;
			byteenable = 4'hF;
			writedata  = data;
			read       = rnw;
			write      = !rnw;
			stalled    = 1'b1;
			while (stalled)
			begin
				#1;
				stalled = waitrequest;
				@(posedge clk);
				if (stalled)
					@(negedge clk);
			end
			@(negedge clk);
			read  = 1'b0;
			write = 1'b0;
		end
	endtask

	task automatic bus_write(input logic [1:0] addr, input logic [31:0] data);
		bus_access(addr, 1'b0, data);
	endtask

	task automatic bus_read(input logic [1:0] addr, output logic [31:0] data);
		begin
			bus_access(addr, 1'b1, 32'h0);
			data = readdata;
		end
	endtask

	// Poll status until ready
	task automatic wait_ready;
		logic [31:0] st;
		begin
			st = 32'h0;
			while (!st[1])
				bus_read(2'd1, st);
		end
	endtask

	task automatic set_control(input logic [1:0] dev, input logic irq_en);
		bus_write(2'd0, {14'h0, dev, 13'h0, 1'b0, irq_en, 1'b0});
	endtask

	task automatic data_write(input logic [7:0] index, input logic [8:0] value);
		begin
			bus_write(2'd2, {24'h0, index});
			bus_write(2'd3, {23'h0, value});
		end
	endtask

	initial
	begin
		reset      = 1'b1;
		address    = 2'd0;
		byteenable = 4'h0;
		read       = 1'b0;
		write      = 1'b0;
		writedata  = 32'h0;
		nack_en    = 1'b0;
		void'($urandom(32'h2daa));
		repeat (10) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		// Writable fields only
		bus_write(2'd0, 32'hFFFF_FFFE);
		bus_read(2'd0, rd);
		check_value(rd, 32'h0003_0006, "control readback");
		bus_write(2'd2, 32'hFFFF_FFFF);
		bus_read(2'd2, rd);
		check_value(rd, 32'h0000_00FF, "address readback");

		// Video writes then reads of the second device
		repeat (3)
		begin
			idx = 8'($urandom);
			d   = {1'b0, 8'($urandom)};
			set_control(2'd1, 1'b0);
			data_write(idx, d);
			wait_ready();
			check_value({8'h0, rec_bytes}, {8'h0, 8'h40, idx, d[7:0]}, "video write bytes");
			check_value({24'h0, u_model.mem[{1'b0, idx}]}, {24'h0, d[7:0]}, "model store");
			bus_read(2'd1, rd);
			check_value(rd, 32'h0000_0102, "status after write");
			idx = 8'($urandom);
			set_control(2'd2, 1'b0);
			bus_write(2'd2, {24'h0, idx});
			exp_rd = {24'h0, u_model.mem[{1'b1, idx}]};
			bus_read(2'd3, rd);
			check_value(rd, exp_rd, "video read data");
		end

		// Codec frame and capture read-back
		idx = 8'($urandom);
		d   = 9'($urandom);
		set_control(2'd0, 1'b0);
		data_write(idx, d);
		wait_ready();
		check_value({8'h0, rec_bytes}, {8'h0, 8'h34, idx[6:0], d[8], d[7:0]}, "codec bytes");
		bus_read(2'd3, rd);
		check_value(rd, {23'h0, d}, "codec capture");

		// Target refuses every byte
		@(negedge clk);
		nack_en = 1'b1;
		set_control(2'd1, 1'b0);
		data_write(8'($urandom), {1'b0, 8'($urandom)});
		wait_ready();
		bus_read(2'd1, rd);
		check_value(rd, 32'h0000_0103, "status after nack");
		nack_en = 1'b0;

		// Interrupt follows ready
		set_control(2'd1, 1'b1);
		check_value({31'h0, irq}, 32'h1, "irq while idle");
		check_value({31'h0, i2c_scen}, 32'h1, "scen while idle");
		data_write(8'($urandom), {1'b0, 8'($urandom)});
		check_value({31'h0, irq}, 32'h0, "irq during transfer");
		// First low phase of the serial clock
		@(negedge i2c_sclk);
		@(negedge clk);
		check_value({31'h0, i2c_scen}, 32'h0, "scen during transfer");
		wait_ready();
		@(negedge clk);
		check_value({31'h0, irq}, 32'h1, "irq after transfer");
		check_value({31'h0, i2c_scen}, 32'h1, "scen after transfer");
		bus_write(2'd0, 32'h0000_0001);
		check_value({31'h0, irq}, 32'h0, "irq after soft reset");
		bus_read(2'd0, rd);
		check_value(rd, 32'h0, "control after soft reset");
		bus_read(2'd2, rd);
		check_value(rd, 32'h0, "address after soft reset");

		errors += UUT.u_asserts.fail_count;
		$display("errors: %0d of %0d checks, assertion failures: %0d", errors, checks,
			UUT.u_asserts.fail_count);
		if (errors == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(watchdog_ns);
		$display("Timeout: the run did not finish in time, %0d errors so far", errors);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
verilog/av_config_pkg.sv
verilog/av_config_regs.sv
verilog/av_config_transfer_fsm.sv
verilog/av_config_frame.sv
verilog/i2c_serial_engine.sv
verilog/av_config.sv
tests/i2c_device_model.sv
tests/av_config_asserts.sv
tests/av_config_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module av_config_tb -f build.f -o av_config_sim
out=$(./obj_dir/av_config_sim +verilator+error+limit+100)
echo "$out"
if echo "$out" | grep -q "^NO ERRORS$"
then
	exit 0
else
	exit 1
fi
